/* include/i2c_consts.svh */
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// System clock in Hz
`define I2C_CLK_FREQ 50000000

// Tick rate, twice the I2C bit rate
`define I2C_HALF_BIT_RATE 200000

// Register word addresses
`define I2C_ADR_DATA 2'd0
`define I2C_ADR_CMD 2'd1

`endif

/* src/i2c_pkg.sv */
package i2c_pkg;

  // Wishbone-style request from the host
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [3:0]  sel;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
  } wb_rsp_t;

  // Lines driven by the controller
  typedef struct packed {
    logic scl;
    logic sda_out;
  } i2c_lines_t;

  typedef enum logic [1:0] {
    CMD_START = 2'd0,
    CMD_STOP  = 2'd1,
    CMD_READ  = 2'd2,
    CMD_WRITE = 2'd3
  } i2c_cmd_e;

  // Write word, view picked by the word address
  typedef union packed {
    struct packed {
      logic [15:0] unused;
      logic [7:0]  addr;
      logic [7:0]  data;
    } data_reg;
    struct packed {
      logic [29:0] unused;
      i2c_cmd_e    cmd;
    } cmd_reg;
  } reg_wdata_u;

endpackage

/* src/i2c_bit_tick.sv */
`include "i2c_consts.svh"

module i2c_bit_tick #(
  parameter int CLK_FREQ  = `I2C_CLK_FREQ,
  parameter int TICK_RATE = `I2C_HALF_BIT_RATE
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic en_i,
  output logic tick_o
);

  localparam int DIV = CLK_FREQ / TICK_RATE;
  localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

  logic [CW-1:0] cnt_q;

  // Count restarts whenever the engine is not running
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (!en_i || tick_o) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tick_o = (cnt_q == CW'(DIV - 1));

  // Count must already be cleared by the time the enable drops
  a_no_tick_when_off: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !en_i |-> !tick_o
  );

endmodule

/* src/i2c_master.sv */
`include "i2c_consts.svh"

module i2c_master #(
  parameter int CLK_FREQ  = `I2C_CLK_FREQ,
  parameter int TICK_RATE = `I2C_HALF_BIT_RATE
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  i2c_pkg::wb_req_t    req_i,
  output i2c_pkg::wb_rsp_t    rsp_o,
  input  logic                sda_i,
  output i2c_pkg::i2c_lines_t lines_o
);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_RESTART,
    ST_RESTART2,
    ST_START,
    ST_WRITE,
    ST_WRITE2,
    ST_SLAVE_ACK,
    ST_SLAVE_ACK2,
    ST_COMPLETE,
    ST_READ,
    ST_READ2,
    ST_READ_END,
    ST_STOP_PREP,
    ST_STOP,
    ST_DONE
  } state_e;

  state_e              state_q, state_d;
  logic [31:0]         result_q, result_d;
  logic [7:0]          addr_q, addr_d;
  logic [7:0]          data_q, data_d;
  logic [7:0]          tx_q, tx_d;
  logic [7:0]          rx_q, rx_d;
  logic [3:0]          bcnt_q, bcnt_d;
  i2c_pkg::i2c_lines_t lines_q, lines_d;
  i2c_pkg::reg_wdata_u wdata;
  logic                tick;
  logic                tick_en;

  assign wdata = req_i.dat;

  // No ticks needed while idle or acknowledging
  assign tick_en = (state_q != ST_IDLE) && (state_q != ST_DONE);

  i2c_bit_tick #(
    .CLK_FREQ (CLK_FREQ),
    .TICK_RATE(TICK_RATE)
  ) u_bit_tick (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .en_i  (tick_en),
    .tick_o(tick)
  );

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      addr_q  <= '0;
      data_q  <= '0;
      rx_q    <= '0;
      bcnt_q  <= '0;
      lines_q <= '1;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      data_q  <= data_d;
      rx_q    <= rx_d;
      bcnt_q  <= bcnt_d;
      lines_q <= lines_d;
    end
  end

  always_ff @(posedge clk_i) begin
    tx_q     <= tx_d;
    result_q <= result_d;
  end

  always_comb begin
    state_d  = state_q;
    result_d = result_q;
    addr_d   = addr_q;
    data_d   = data_q;
    tx_d     = tx_q;
    rx_d     = rx_q;
    bcnt_d   = bcnt_q;
    lines_d  = lines_q;
    case (state_q)
      ST_IDLE: begin
        if (req_i.cyc && req_i.stb) begin
          state_d = ST_DONE;
          case (req_i.adr)
            `I2C_ADR_DATA: begin
              if (req_i.we) begin
                if (req_i.sel[1]) begin
                  addr_d = wdata.data_reg.addr;
                end
                if (req_i.sel[0]) begin
                  data_d = wdata.data_reg.data;
                end
              end else begin
                result_d = {16'h0, addr_q, rx_q};
              end
            end
            `I2C_ADR_CMD: begin
              if (!req_i.we) begin
                result_d = {29'h0, sda_i, lines_q.sda_out, lines_q.scl};
              end else if (req_i.sel[0]) begin
                case (wdata.cmd_reg.cmd)
                  // Clock low means a transfer is open, so restart
                  i2c_pkg::CMD_START: state_d = lines_q.scl ? ST_START : ST_RESTART;
                  i2c_pkg::CMD_STOP: begin
                    // Data must be low before the clock rises
                    if (!lines_q.scl && lines_q.sda_out) begin
                      state_d = ST_STOP_PREP;
                    end else begin
                      state_d = ST_STOP;
                    end
                  end
                  i2c_pkg::CMD_READ: begin
                    bcnt_d          = 4'd7;
                    lines_d.sda_out = 1'b1;
                    state_d         = ST_READ;
                  end
                  i2c_pkg::CMD_WRITE: begin
                    bcnt_d  = 4'd7;
                    tx_d    = data_q;
                    state_d = ST_WRITE;
                  end
                endcase
              end
            end
            default: ;
          endcase
        end
      end
      ST_RESTART: begin
        lines_d.sda_out = 1'b1;
        if (tick) begin
          state_d = ST_RESTART2;
        end
      end
      ST_RESTART2: begin
        lines_d.scl = 1'b1;
        if (tick) begin
          state_d = ST_START;
        end
      end
      ST_START: begin
        // Data falls with the clock high
        lines_d.sda_out = 1'b0;
        lines_d.scl     = 1'b1;
        if (tick) begin
          lines_d.scl = 1'b0;
          bcnt_d      = 4'd7;
          tx_d        = addr_q;
          state_d     = ST_WRITE;
        end
      end
      ST_WRITE: begin
        lines_d.sda_out = tx_q[bcnt_q[2:0]];
        if (tick) begin
          lines_d.scl = 1'b1;
          state_d     = ST_WRITE2;
        end
      end
      ST_WRITE2: begin
        if (tick) begin
          lines_d.scl = 1'b0;
          if (bcnt_q != 4'd0) begin
            bcnt_d  = bcnt_q - 4'd1;
            state_d = ST_WRITE;
          end else begin
            state_d = ST_SLAVE_ACK;
          end
        end
      end
      ST_SLAVE_ACK: begin
        // Release data for the target's acknowledge
        lines_d.sda_out = 1'b1;
        if (tick) begin
          lines_d.scl = 1'b1;
          state_d     = ST_SLAVE_ACK2;
        end
      end
      ST_SLAVE_ACK2: begin
        if (tick) begin
          lines_d.scl = 1'b0;
          state_d     = ST_COMPLETE;
        end
      end
      ST_COMPLETE: begin
        if (tick) begin
          lines_d.sda_out = 1'b0;
          state_d         = ST_DONE;
        end
      end
      ST_READ: begin
        if (tick) begin
          lines_d.scl = 1'b1;
          state_d     = ST_READ2;
        end
      end
      ST_READ2: begin
        if (tick) begin
          lines_d.scl = 1'b0;
          rx_d        = {rx_q[6:0], sda_i};
          if (bcnt_q != 4'd0) begin
            bcnt_d  = bcnt_q - 4'd1;
            state_d = ST_READ;
          end else begin
            state_d = ST_READ_END;
          end
        end
      end
      // No master acknowledge, data stays released
      ST_READ_END: state_d = ST_DONE;
      ST_STOP_PREP: begin
        lines_d.sda_out = 1'b0;
        if (tick) begin
          state_d = ST_STOP;
        end
      end
      ST_STOP: begin
        lines_d.scl = 1'b1;
        if (tick) begin
          lines_d.sda_out = 1'b1;
          state_d         = ST_DONE;
        end
      end
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  assign rsp_o.dat = result_q;
  assign rsp_o.ack = (state_q == ST_DONE);
  assign lines_o   = lines_q;

  a_ack_single: assert property (
    @(posedge clk_i) disable iff (rst_i)
    rsp_o.ack |=> !rsp_o.ack
  );

  a_bcnt_range: assert property (
    @(posedge clk_i) disable iff (rst_i)
    bcnt_q <= 4'd7
  );

  // Data edges under a high clock are start or stop conditions
  a_sda_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (lines_q.scl && $past(lines_q.scl) && (lines_q.sda_out != $past(lines_q.sda_out)))
      |-> ($past(state_q) inside {ST_START, ST_STOP, ST_RESTART})
  );

endmodule

/* src/i2c_wb_top.sv */
`include "i2c_consts.svh"

module i2c_wb_top #(
  parameter int CLK_FREQ  = `I2C_CLK_FREQ,
  parameter int TICK_RATE = `I2C_HALF_BIT_RATE
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  i2c_pkg::wb_req_t    wb_req_i,
  output i2c_pkg::wb_rsp_t    wb_rsp_o,
  input  logic                sda_i,
  output i2c_pkg::i2c_lines_t lines_o
);

  i2c_pkg::wb_rsp_t    rsp;
  i2c_pkg::i2c_lines_t lines;

  i2c_master #(
    .CLK_FREQ (CLK_FREQ),
    .TICK_RATE(TICK_RATE)
  ) u_master (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req_i  (wb_req_i),
    .rsp_o  (rsp),
    .sda_i  (sda_i),
    .lines_o(lines)
  );

  // Host side and pin side
  assign wb_rsp_o = rsp;
  assign lines_o  = lines;

endmodule

/* tests/i2c_checker.sv */
module i2c_checker (
  input  logic                clk_i,
  input  logic                rst_i,
  input  i2c_pkg::wb_req_t    wb_req_i,
  input  i2c_pkg::wb_rsp_t    wb_rsp_i,
  input  i2c_pkg::i2c_lines_t lines_i,
  input  logic                sda_i,
  input  logic                done_i,
  input  logic                timeout_i,
  input  logic                finish_i,
  input  int                  test_i,
  input  logic [3:0]          chk_i,
  input  logic [7:0]          exp_byte_i,
  input  logic [31:0]         exp_rd_i,
  input  i2c_pkg::i2c_lines_t exp_lines_i,
  output int                  fail_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic        scl_q;
  logic        sda_q;
  logic        saw_start;
  logic        saw_stop;
  logic        ok;
  logic [7:0]  shreg;
  logic [7:0]  last_byte;
  logic [31:0] rd_q;
  int          nbits;
  int          nbytes;
  int          pass_cnt;
  int          fail_cnt;
  int          err_cnt;

  assign fail_cnt_o = fail_cnt + err_cnt;

  // Lines only move on rising edges, so sample them on the falling edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      scl_q     = 1'b1;
      sda_q     = 1'b1;
      saw_start = 1'b0;
      saw_stop  = 1'b0;
      shreg     = '0;
      last_byte = '0;
      rd_q      = '0;
      nbits     = 0;
      nbytes    = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      err_cnt   = 0;
    end else begin
      // Data edge with the clock high
      if (lines_i.scl && scl_q && (sda_q != sda_i)) begin
        if (sda_i) begin
          saw_stop = 1'b1;
        end else begin
          saw_start = 1'b1;
          nbits     = 0;
        end
      end
      // Ninth rising clock is the acknowledge slot
      if (lines_i.scl && !scl_q) begin
        if (nbits < 8) begin
          shreg = {shreg[6:0], sda_i};
        end
        if (nbits == 7) begin
          last_byte = shreg;
          nbytes++;
        end
        nbits = (nbits == 8) ? 0 : nbits + 1;
      end
      scl_q = lines_i.scl;
      sda_q = sda_i;
      if (wb_rsp_i.ack && !(wb_req_i.cyc && wb_req_i.stb)) begin
        $display("Error %0d ns: wb_rsp.ack expected 0 actual 1", $time);
        err_cnt++;
      end
      if (wb_rsp_i.ack && !wb_req_i.we) begin
        rd_q = wb_rsp_i.dat;
      end
      if (done_i) begin
        ok = 1'b0;
        if (timeout_i) begin
          $display("Test %0d: the DUT never acknowledged the request", test_i);
        end else if (chk_i[2] && !saw_start) begin
          $display("Test %0d: no start condition appeared on the lines", test_i);
        end else if (chk_i[3] && !saw_stop) begin
          $display("Test %0d: no stop condition appeared on the lines", test_i);
        end else if (chk_i[1] && (nbytes != 1)) begin
          $display("Test %0d: expected one byte on the lines but saw %0d", test_i, nbytes);
        end else if (chk_i[1] && (last_byte != exp_byte_i)) begin
          $display("Error %0d ns: test %0d i2c_byte expected 8'h%02h actual 8'h%02h",
                   $time, test_i, exp_byte_i, last_byte);
        end else if (chk_i[0] && (rd_q != exp_rd_i)) begin
          $display("Error %0d ns: test %0d wb_rsp.dat expected 32'h%08h actual 32'h%08h",
                   $time, test_i, exp_rd_i, rd_q);
        end else if (lines_i != exp_lines_i) begin
          $display("Error %0d ns: test %0d lines_o expected 2'b%02b actual 2'b%02b",
                   $time, test_i, exp_lines_i, lines_i);
        end else begin
          ok = 1'b1;
          $display("Test %0d passed", test_i);
        end
        if (ok) begin
          pass_cnt++;
        end else begin
          fail_cnt++;
        end
        saw_start = 1'b0;
        saw_stop  = 1'b0;
        nbytes    = 0;
      end
      if (finish_i) begin
        $display("Tests passed %0d, failed %0d, bus errors %0d", pass_cnt, fail_cnt, err_cnt);
      end
    end
  end

endmodule

/* tests/i2c_tb.sv */
`include "i2c_consts.svh"

module i2c_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TICK_CYCLES = 4;
  localparam int ACK_TIMEOUT = 1000;
  localparam logic [3:0] CHK_RD    = 4'b0001;
  localparam logic [3:0] CHK_BYTE  = 4'b0010;
  localparam logic [3:0] CHK_START = 4'b0100;
  localparam logic [3:0] CHK_STOP  = 4'b1000;

  typedef struct packed {
    logic [1:0]          adr;
    logic                we;
    logic [3:0]          sel;
    logic [31:0]         wdat;
    logic                tgt_en;
    logic [7:0]          tgt;
    logic [3:0]          chk;
    logic [7:0]          exp_byte;
    logic [31:0]         exp_rd;
    i2c_pkg::i2c_lines_t exp_lines;
  } row_t;

  logic                clk_i;
  logic                rst_i;
  i2c_pkg::wb_req_t    wb_req;
  i2c_pkg::wb_rsp_t    wb_rsp;
  i2c_pkg::i2c_lines_t lines;
  logic                sda_line;
  logic                tgt_load;
  logic                scl_seen;
  logic [7:0]          tgt_byte;
  logic [7:0]          tgt_shift;
  int                  tgt_bits;
  row_t                rows[$];
  row_t                cur;
  i2c_pkg::i2c_lines_t cur_lines;
  logic [7:0]          addr_exp;
  logic [31:0]         rng;
  logic                done;
  logic                timeout;
  logic                finish;
  logic                timed_out;
  int                  test_id;
  int                  fail_cnt;

  always #10 clk_i = ~clk_i;

  i2c_wb_top #(
    .CLK_FREQ (`I2C_CLK_FREQ),
    .TICK_RATE(`I2C_CLK_FREQ / TICK_CYCLES)
  ) DUT (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wb_req_i(wb_req),
    .wb_rsp_o(wb_rsp),
    .sda_i   (sda_line),
    .lines_o (lines)
  );

  i2c_checker u_checker (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_req_i   (wb_req),
    .wb_rsp_i   (wb_rsp),
    .lines_i    (lines),
    .sda_i      (sda_line),
    .done_i     (done),
    .timeout_i  (timeout),
    .finish_i   (finish),
    .test_i     (test_id),
    .chk_i      (cur.chk),
    .exp_byte_i (cur.exp_byte),
    .exp_rd_i   (cur.exp_rd),
    .exp_lines_i(cur.exp_lines),
    .fail_cnt_o (fail_cnt)
  );

  // Open drain data line
  assign sda_line = lines.sda_out & ((tgt_bits > 0) ? tgt_shift[7] : 1'b1);

  // Target shifts its byte out MSB first after each falling clock
  always @(posedge clk_i) begin
    if (rst_i) begin
      scl_seen  <= 1'b1;
      tgt_shift <= '0;
      tgt_bits  <= 0;
    end else begin
      scl_seen <= lines.scl;
      if (tgt_load) begin
        tgt_shift <= tgt_byte;
        tgt_bits  <= 8;
      end else if (scl_seen && !lines.scl && (tgt_bits > 0)) begin
        tgt_shift <= {tgt_shift[6:0], 1'b0};
        tgt_bits  <= tgt_bits - 1;
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic push_row(input logic [1:0] adr, input logic we, input logic [3:0] sel,
                          input logic [31:0] wdat, input logic [3:0] chk,
                          input logic [7:0] ebyte, input logic [31:0] erd,
                          input logic tgt_en, input logic [7:0] tgt);
    rows.push_back(row_t'{adr, we, sel, wdat, tgt_en, tgt, chk, ebyte, erd, cur_lines});
  endtask

  task automatic write_row(input logic [1:0] adr, input logic [3:0] sel, input logic [31:0] d);
    push_row(adr, 1'b1, sel, d, 4'b0000, 8'h00, 32'h0, 1'b0, 8'h00);
  endtask

  task automatic read_row(input logic [1:0] adr, input logic [31:0] erd);
    push_row(adr, 1'b0, 4'b1111, 32'h0, CHK_RD, 8'h00, erd, 1'b0, 8'h00);
  endtask

  task automatic command_row(input i2c_pkg::i2c_cmd_e cmd, input logic [3:0] chk,
                             input logic [7:0] ebyte, input i2c_pkg::i2c_lines_t elines,
                             input logic tgt_en, input logic [7:0] tgt);
    cur_lines = elines;
    push_row(`I2C_ADR_CMD, 1'b1, 4'b0001, {30'h0, cmd}, chk, ebyte, 32'h0, tgt_en, tgt);
  endtask

  task automatic build_table();
    cur_lines = 2'b11;
    read_row(`I2C_ADR_CMD, 32'h0000_0007);
    write_row(`I2C_ADR_CMD, 4'b1110, 32'h0000_0000);
    read_row(`I2C_ADR_CMD, 32'h0000_0007);
    write_row(`I2C_ADR_DATA, 4'b0011, 32'h0000_a55a);
    read_row(`I2C_ADR_DATA, 32'h0000_a500);
    write_row(`I2C_ADR_DATA, 4'b0001, 32'h0000_ff3c);
    read_row(`I2C_ADR_DATA, 32'h0000_a500);
    write_row(`I2C_ADR_DATA, 4'b1100, 32'h1234_5678);
    read_row(`I2C_ADR_DATA, 32'h0000_a500);
    addr_exp = 8'ha5;
    for (int k = 0; k < 4; k++) begin
      rng = xorshift32(rng);
      if (rng[17]) begin
        addr_exp = rng[15:8];
      end
      write_row(`I2C_ADR_DATA, {2'b00, rng[17:16]}, rng);
      read_row(`I2C_ADR_DATA, {16'h0, addr_exp, 8'h00});
    end
    write_row(`I2C_ADR_DATA, 4'b0011, 32'h0000_a63c);
    read_row(`I2C_ADR_DATA, 32'h0000_a600);
    // Data byte must keep 8'h3c with sel bit 0 clear
    write_row(`I2C_ADR_DATA, 4'b0010, 32'h0000_a6c3);
    command_row(i2c_pkg::CMD_START, CHK_START | CHK_BYTE, 8'ha6, 2'b00, 1'b0, 8'h00);
    command_row(i2c_pkg::CMD_WRITE, CHK_BYTE, 8'h3c, 2'b00, 1'b0, 8'h00);
    // Clock is low now, so this one is a repeated start
    command_row(i2c_pkg::CMD_START, CHK_START | CHK_BYTE, 8'ha6, 2'b00, 1'b0, 8'h00);
    command_row(i2c_pkg::CMD_READ, CHK_BYTE, 8'h96, 2'b01, 1'b1, 8'h96);
    // Released data with the clock low
    read_row(`I2C_ADR_CMD, 32'h0000_0006);
    read_row(`I2C_ADR_DATA, 32'h0000_a696);
    command_row(i2c_pkg::CMD_STOP, CHK_STOP, 8'h00, 2'b11, 1'b0, 8'h00);
    read_row(`I2C_ADR_CMD, 32'h0000_0007);
  endtask

  task automatic run_row(input int idx);
    logic got_ack;
    int   waited;
    got_ack = 1'b0;
    waited  = 0;
    @(posedge clk_i);
    test_id  <= idx;
    cur      <= rows[idx];
    tgt_load <= rows[idx].tgt_en;
    tgt_byte <= rows[idx].tgt;
    wb_req   <= '{cyc: 1'b1, stb: 1'b1, we: rows[idx].we, adr: rows[idx].adr,
                  sel: rows[idx].sel, dat: rows[idx].wdat};
    @(posedge clk_i);
    tgt_load <= 1'b0;
    while (!got_ack && (waited < ACK_TIMEOUT)) begin
      @(negedge clk_i);
      got_ack = wb_rsp.ack;
      waited++;
    end
    @(posedge clk_i);
    wb_req    <= '0;
    timeout   <= !got_ack;
    done      <= 1'b1;
    timed_out = !got_ack;
    @(posedge clk_i);
    done <= 1'b0;
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    wb_req    = '0;
    tgt_load  = 1'b0;
    tgt_byte  = '0;
    cur       = '0;
    done      = 1'b0;
    timeout   = 1'b0;
    finish    = 1'b0;
    timed_out = 1'b0;
    test_id   = 0;
    rng       = 32'h3f5e_8808;
    build_table();
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
      if (timed_out) begin
        break;
      end
    end
    @(posedge clk_i);
    finish <= 1'b1;
    @(posedge clk_i);
    finish <= 1'b0;
    @(posedge clk_i);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
src/i2c_pkg.sv
src/i2c_bit_tick.sv
src/i2c_master.sv
src/i2c_wb_top.sv
tests/i2c_checker.sv
tests/i2c_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the I2C controller simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module i2c_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vi2c_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  exit 0
fi
exit 1
